// ==== uart_tx_pkg.sv ====
package uart_tx_pkg;

	// frame layout: start, data lsb first, even parity, stop
	localparam int DATA_W     = 8;          // data bits per frame
	localparam int FRAME_BITS = DATA_W + 3; // start + data + parity + stop

	// width of a counter that walks every bit position of a frame
	localparam int BIT_IDX_W = $clog2(FRAME_BITS);

	// line levels
	localparam logic START_BIT = 1'b0; // line pulled low to open a frame
	localparam logic STOP_BIT  = 1'b1; // also the idle level of the line

	// one data byte as it moves from producer to line
	typedef logic [DATA_W-1:0] byte_t;

endpackage

// ==== baud_generator.sv ====
`timescale 1ns/1ps

module baud_generator #(
	parameter int CLKS_PER_BIT = 5000 // 48 MHz / 9600 baud
) (
	input  logic clk,       // system clock
	input  logic i_rst,     // synchronous active high reset
	input  logic i_restart, // realign bit period to a new frame
	output logic o_tick     // one-cycle pulse per bit period
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_BIT - 1);

	logic [CNT_W-1:0] cnt; // down counter that ticks at zero

	always_ff @(posedge clk) begin
		if (i_rst || i_restart) begin
			cnt <= RELOAD; // full period from here on
		end else if (cnt == '0) begin
			cnt <= RELOAD; // wrap into the next period
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// tick lands exactly CLKS_PER_BIT cycles after a restart cycle
	assign o_tick = (cnt == '0);

	// a one-cycle period would leave tick stuck high
	initial begin
		assert (CLKS_PER_BIT >= 2)
			else $error("baud_generator needs at least two clocks per bit");
	end

endmodule

// ==== tx_req_ack_port.sv ====
`timescale 1ns/1ps

module tx_req_ack_port
	import uart_tx_pkg::*;
(
	input  logic  clk,       // system clock
	input  logic  i_rst,     // sync reset, active high
	input  logic  i_req,     // producer request, four phase
	input  byte_t i_data,    // held stable while i_req is high
	input  logic  i_full,    // fifo has no free slot
	output logic  o_ack,     // byte stored, producer may drop req
	output logic  o_wr_en,   // one pulse per handshake
	output byte_t o_wr_data  // byte captured from the producer
);

	localparam logic ST_WAIT  = 1'b0; // waiting for a new request
	localparam logic ST_ACKED = 1'b1; // ack up, waiting for req to drop

	logic state;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state   <= ST_WAIT;
			o_wr_en <= 1'b0;
		end else begin
			o_wr_en <= 1'b0; // default, pulse only
			case (state)
				ST_WAIT: begin
					if (i_req && !i_full) begin // hold off ack while full
						state   <= ST_ACKED;
						o_wr_en <= 1'b1; // write goes in with the ack
					end
				end
				ST_ACKED: begin
					if (!i_req) state <= ST_WAIT; // phase 3 seen, drop ack
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	// payload only, no reset needed
	always_ff @(posedge clk) begin
		if (state == ST_WAIT && i_req) o_wr_data <= i_data;
	end

	assign o_ack = (state == ST_ACKED);

	// ack must answer a live request, never an idle line
	a_ack_needs_req: assert property (@(posedge clk) disable iff (i_rst)
		$rose(o_ack) |-> i_req)
		else $error("o_ack rose while i_req was low");

endmodule

// ==== tx_fifo.sv ====
`timescale 1ns/1ps

module tx_fifo
	import uart_tx_pkg::*;
#(
	parameter int FIFO_AW = 4 // depth is 2**FIFO_AW
) (
	input  logic  clk,       // system clock
	input  logic  i_rst,     // sync reset, active high
	input  logic  i_wr_en,   // push i_wr_data
	input  byte_t i_wr_data, // byte from the handshake port
	input  logic  i_rd_en,   // pop, data shows next cycle
	output byte_t o_rd_data, // head byte, held until next pop
	output logic  o_full,    // no free slot
	output logic  o_empty    // nothing queued
);

	localparam int DEPTH = 2 ** FIFO_AW;

	byte_t              mem [DEPTH]; // storage, no reset
	logic [FIFO_AW-1:0] wr_ptr;      // next slot to write
	logic [FIFO_AW-1:0] rd_ptr;      // next slot to read
	logic [FIFO_AW:0]   count;       // occupancy, one extra bit for full
	logic               do_wr;       // qualified write
	logic               do_rd;       // qualified read

	assign do_wr = i_wr_en && !o_full;
	assign do_rd = i_rd_en && !o_empty;

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none, or push and pop together
			endcase
		end
	end

	// storage write port
	always_ff @(posedge clk) begin
		if (do_wr) mem[wr_ptr] <= i_wr_data;
	end

	// registered read port, payload only
	always_ff @(posedge clk) begin
		if (do_rd) o_rd_data <= mem[rd_ptr];
	end

	// flags follow count, so a write into empty clears empty next cycle
	assign o_full  = (count == (FIFO_AW+1)'(DEPTH));
	assign o_empty = (count == '0);

	// upstream must respect full
	a_no_overflow: assert property (@(posedge clk) disable iff (i_rst)
		!(i_wr_en && o_full))
		else $error("write into a full fifo");

	// downstream must respect empty
	a_no_underflow: assert property (@(posedge clk) disable iff (i_rst)
		!(i_rd_en && o_empty))
		else $error("read from an empty fifo");

endmodule

// ==== tx_serializer.sv ====
`timescale 1ns/1ps

module tx_serializer
	import uart_tx_pkg::*;
(
	input  logic  clk,       // system clock
	input  logic  i_rst,     // synchronous active high reset
	input  logic  i_empty,   // fifo has no byte waiting
	input  byte_t i_rd_data, // head byte valid the cycle after a pop
	input  logic  i_tick,    // end of the current bit period
	output logic  o_rd_en,   // pop one byte
	output logic  o_restart, // realign the baud generator
	output logic  o_tx,      // serial line
	output logic  o_busy     // frame on the line
);

	localparam logic [2:0] ST_IDLE   = 3'd0; // line idle with the fifo empty
	localparam logic [2:0] ST_LOAD   = 3'd1; // popped byte arriving while baud restarts
	localparam logic [2:0] ST_START  = 3'd2; // start bit
	localparam logic [2:0] ST_DATA   = 3'd3; // eight data bits, lsb first
	localparam logic [2:0] ST_PARITY = 3'd4; // even parity bit
	localparam logic [2:0] ST_STOP   = 3'd5; // stop bit

	logic [2:0]           state;
	logic [DATA_W:0]      shreg;   // parity over the data byte shifting right
	logic [BIT_IDX_W-1:0] bit_idx; // frame position counted from the start bit
	logic                 chain;   // next byte ready at end of stop

	assign chain = (state == ST_STOP) && i_tick && !i_empty;

	// pop when leaving idle or when chaining into the next frame
	assign o_rd_en   = ((state == ST_IDLE) && !i_empty) || chain;
	assign o_restart = (state == ST_LOAD); // start bit gets a full period

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state   <= ST_IDLE;
			bit_idx <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (!i_empty) state <= ST_LOAD;
				end
				ST_LOAD: begin
					state   <= ST_START; // byte now on i_rd_data
					bit_idx <= '0;
				end
				ST_START: begin
					if (i_tick) begin
						state   <= ST_DATA;
						bit_idx <= bit_idx + 1'b1;
					end
				end
				ST_DATA: begin
					if (i_tick) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == BIT_IDX_W'(DATA_W)) state <= ST_PARITY; // last data bit
					end
				end
				ST_PARITY: begin
					if (i_tick) begin
						state   <= ST_STOP;
						bit_idx <= bit_idx + 1'b1;
					end
				end
				ST_STOP: begin
					if (chain) begin
						state   <= ST_START; // back to back on an already aligned baud
						bit_idx <= '0;
					end else if (i_tick) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// shift register loads as the start bit ends
	always_ff @(posedge clk) begin
		if (state == ST_START && i_tick) begin
			shreg <= {^i_rd_data, i_rd_data}; // even parity on top
		end else if (state == ST_DATA && i_tick) begin
			shreg <= shreg >> 1; // lsb first until parity lands in bit 0
		end
	end

	always_comb begin
		case (state)
			ST_START:          o_tx = START_BIT;
			ST_DATA, ST_PARITY: o_tx = shreg[0];
			default:           o_tx = STOP_BIT; // idle, load, stop
		endcase
	end

	assign o_busy = (state != ST_IDLE) && (state != ST_LOAD);

	// line rests high whenever no frame is out
	a_idle_high: assert property (@(posedge clk) disable iff (i_rst)
		!o_busy |-> o_tx)
		else $error("tx line low while not busy");

endmodule

// ==== uart_tx_top.sv ====
`timescale 1ns/1ps

module uart_tx_top
	import uart_tx_pkg::*;
#(
	parameter int CLKS_PER_BIT = 5000, // 48 MHz / 9600 baud
	parameter int FIFO_AW      = 4     // 16 byte queue
) (
	input  logic  clk,    // system clock
	input  logic  i_rst,  // sync reset, active high
	input  logic  i_req,  // producer request
	input  byte_t i_data, // producer byte
	output logic  o_ack,  // producer acknowledge
	output logic  o_tx,   // serial line
	output logic  o_busy  // frame on the line
);

	logic  wr_en;      // port to fifo push
	byte_t wr_data;    // port to fifo byte
	logic  full;       // fifo back-pressure
	logic  empty;      // fifo has nothing for the serializer
	byte_t rd_data;    // fifo head byte
	logic  rd_en;      // serializer pop
	logic  bg_restart; // serializer realigns baud at frame start
	logic  tick;       // one pulse per bit period

	tx_req_ack_port u_port (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_req     (i_req),
		.i_data    (i_data),
		.i_full    (full),
		.o_ack     (o_ack),
		.o_wr_en   (wr_en),
		.o_wr_data (wr_data)
	);

	tx_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_wr_en   (wr_en),
		.i_wr_data (wr_data),
		.i_rd_en   (rd_en),
		.o_rd_data (rd_data),
		.o_full    (full),
		.o_empty   (empty)
	);

	baud_generator #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_baud (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_restart (bg_restart),
		.o_tick    (tick)
	);

	tx_serializer u_ser (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_empty   (empty),
		.i_rd_data (rd_data),
		.i_tick    (tick),
		.o_rd_en   (rd_en),
		.o_restart (bg_restart),
		.o_tx      (o_tx),
		.o_busy    (o_busy)
	);

endmodule

// ==== tb_uart_tx.sv ====
`timescale 1ns/1ps

module tb_uart_tx
	import uart_tx_pkg::*;
();

	localparam int CLKS      = 16;                // clocks per bit on this bench
	localparam int AW        = 4;                 // fifo depth 16
	localparam int FRAME_CYC = FRAME_BITS * CLKS; // 176 clocks per frame

	logic  clk;
	logic  i_rst;
	logic  i_req;
	byte_t i_data;
	logic  o_ack;
	logic  o_tx;
	logic  o_busy;

	string cur_name = "reset"; // test name for error lines
	int    errors   = 0;
	int    checks   = 0;
	byte_t exp_q[$];           // bytes handed over, file order
	byte_t rx_q[$];            // bytes decoded from the line
	int    busy_q[$];          // length of each busy period

	uart_tx_top #(.CLKS_PER_BIT(CLKS), .FIFO_AW(AW)) dut (
		.clk    (clk),
		.i_rst  (i_rst),
		.i_req  (i_req),
		.i_data (i_data),
		.o_ack  (o_ack),
		.o_tx   (o_tx),
		.o_busy (o_busy)
	);

	always #20 clk = ~clk; // 40 ns period

	task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
		checks++;
		if (exp_v !== act_v) begin
			errors++;
			$display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
		end
	endtask

	// waits at falling edges until sig reaches level, gives up after limit cycles
	task automatic wait_level(input string sig, input logic level, input int limit,
			output int cycles, output logic ok);
		ok     = 1'b0;
		cycles = 0;
		while (!ok && cycles < limit) begin
			@(negedge clk);
			cycles++;
			ok = (((sig == "o_ack") ? o_ack : o_busy) == level);
		end
		if (!ok) begin
			errors++;
			$display("ERROR %s: %s did not reach %0b within %0d cycles", cur_name, sig, level, limit);
		end
	endtask

	// one four-phase handshake, stall is the wait for ack in cycles
	task automatic send_byte(input byte_t b, output int stall, output logic ok);
		int drop;
		@(posedge clk);
		i_data <= b;
		i_req  <= 1'b1;
		wait_level("o_ack", 1'b1, 4 * FRAME_CYC, stall, ok);
		@(posedge clk);
		i_req <= 1'b0; // phase 3
		if (ok) wait_level("o_ack", 1'b0, 4 * CLKS, drop, ok);
	endtask

	// line decoder, samples each bit in its middle and watches for glitches
	int                    dec_cyc = 0;    // clock within the current frame
	logic                  dec_on  = 1'b0; // frame being decoded
	logic                  tx_prev = 1'b1; // line one clock ago
	logic [FRAME_BITS-1:0] dec_bits;       // start bit in bit 0
	byte_t                 dec_byte;

	always @(negedge clk) begin
		if (!i_rst) begin
			if (!dec_on && tx_prev && !o_tx) begin // falling edge opens a frame
				dec_on  = 1'b1;
				dec_cyc = 0;
			end
			if (dec_on) begin
				if (dec_cyc % CLKS != 0 && o_tx != tx_prev) begin
					errors++;
					$display("ERROR %s: line changed inside a bit period", cur_name);
				end
				if (dec_cyc % CLKS == CLKS / 2) dec_bits[dec_cyc / CLKS] = o_tx; // mid bit
				if (dec_cyc == FRAME_CYC - 1) begin
					dec_byte = dec_bits[DATA_W:1];
					check({cur_name, " start bit"}, 0, dec_bits[0]);
					check({cur_name, " parity bit"}, ^dec_byte, dec_bits[DATA_W+1]); // even
					check({cur_name, " stop bit"}, 1, dec_bits[FRAME_BITS-1]);
					rx_q.push_back(dec_byte);
					dec_on = 1'b0;
				end
				dec_cyc++;
			end
		end
		tx_prev = o_tx;
	end

	// busy length and handshake ordering
	int   busy_cyc  = 0;
	logic busy_prev = 1'b0;
	logic ack_prev  = 1'b0;
	logic req_prev  = 1'b0;

	always @(negedge clk) begin
		if (!i_rst) begin
			if (o_busy) begin
				busy_cyc++;
			end else if (busy_prev) begin
				busy_q.push_back(busy_cyc); // one entry per busy period
				busy_cyc = 0;
			end
			if (o_ack && !ack_prev) check({cur_name, " ack rise needs req"}, 1, i_req);
			if (!o_ack && ack_prev) check({cur_name, " ack fall after req"}, 0, req_prev);
		end
		busy_prev = o_busy;
		ack_prev  = o_ack;
		req_prev  = i_req;
	end

	initial begin
		int          fd;
		int          c;
		int          cnt;
		int          stall;
		int          max_stall;
		int          waited;
		logic [31:0] val;
		logic        ok;
		logic        aborted;
		string       name;
		clk     = 1'b0;
		i_rst   = 1'b1;
		i_req   = 1'b0;
		i_data  = '0;
		aborted = 1'b0;
		void'($urandom(32'h4425_4e0d));
		repeat (5) @(posedge clk);
		i_rst <= 1'b0;
		repeat (50) begin // quiet line after reset
			@(negedge clk);
			check("reset o_tx", 1, o_tx);
			check("reset o_busy", 0, o_busy);
			check("reset o_ack", 0, o_ack);
		end
		fd = $fopen("uart_tx_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("ERROR: could not open the stimulus file uart_tx_stim.txt");
			aborted = 1'b1;
		end
		while (!aborted && $fscanf(fd, "%s", name) == 1) begin
			if (name.getc(0) == "#") begin // comment, skip to end of line
				do begin
					c = $fgetc(fd);
				end while (c != 10 && c != -1);
				continue;
			end
			cur_name = name;
			void'($fscanf(fd, "%d", cnt));
			for (int i = 0; i < cnt; i++) begin
				void'($fscanf(fd, "%h", val));
				exp_q.push_back(val[7:0]);
			end
			repeat ($urandom_range(8)) @(posedge clk); // idle gap before each group
			max_stall = 0;
			foreach (exp_q[i]) begin
				if (!aborted) begin
					send_byte(exp_q[i], stall, ok); // group goes out with no gaps
					aborted = !ok;
					if (stall > max_stall) max_stall = stall;
				end
			end
			if (!aborted) wait_level("o_busy", 1'b1, 4 * CLKS, waited, ok);
			if (!aborted && ok) wait_level("o_busy", 1'b0, cnt * FRAME_CYC + 4 * CLKS, waited, ok);
			aborted = aborted || !ok;
			if (!aborted) begin
				repeat (2) @(negedge clk); // let the monitors settle
				check({name, " byte count"}, cnt, rx_q.size());
				for (int i = 0; i < cnt && i < rx_q.size(); i++) begin
					check({name, $sformatf(" byte %0d", i)}, exp_q[i], rx_q[i]);
				end
				check({name, " busy periods"}, 1, busy_q.size()); // frames back to back
				if (busy_q.size() > 0) check({name, " busy cycles"}, cnt * FRAME_CYC, busy_q[0]);
				if (cnt > 2 ** AW + 1) check({name, " ack stall"}, 1, max_stall > CLKS);
			end
			exp_q.delete();
			rx_q.delete();
			busy_q.delete();
		end
		if (fd != 0) $fclose(fd);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== uart_tx_stim.txt ====
# columns: test name, byte count, then that many bytes in hex
# bytes of one line go out back to back, random idle gap between lines
single_a5 1 a5
single_00 1 00
single_ff 1 ff
single_01 1 01
single_80 1 80
single_7e 1 7e
pair 2 3c c3
triple 3 55 aa 96
nibbles 4 0f f0 12 34
burst24 24 10 21 32 43 54 65 76 87 98 a9 ba cb dc ed fe 0f 5a a5 3c c3 e7 18 81 7f
after_burst 1 c6
odd_pair 2 07 e0

// ==== sim.f ====
uart_tx_pkg.sv
baud_generator.sv
tx_req_ack_port.sv
tx_fifo.sv
tx_serializer.sv
uart_tx_top.sv
tb_uart_tx.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_uart_tx
FILELIST  ?= sim.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
